/* common/fetch_pkg.sv */
package fetch_pkg;

  localparam logic [31:0] RESET_PC = 32'h8000_0000;
  localparam logic [7:0] BYPASS_REGION = 8'h0f;  // top address byte of uncached sram

  localparam int INST_BYTES = 4;

  // cache geometry
  localparam int LINE_COUNT = 4;
  localparam int WORDS_PER_LINE = 2;
  localparam int LINE_BITS = $clog2(LINE_COUNT);
  localparam int BEAT_BITS = $clog2(WORDS_PER_LINE);
  localparam int OFFSET_BITS = BEAT_BITS + 2;  // byte offset inside a line
  localparam int TAG_BITS = 32 - LINE_BITS - OFFSET_BITS;

  // axi4 read channel encodings
  localparam logic [2:0] AXI_SIZE_4B = 3'b010;
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
  localparam logic [7:0] REFILL_LEN = 8'(WORDS_PER_LINE - 1);  // beats minus one

  localparam logic [3:0] MCAUSE_FETCH_FAULT = 4'd1;

  typedef enum logic [2:0] {
    st_idle        = 3'd0,  // serve a hit or start a read
    st_refill      = 3'd1,
    st_direct      = 3'd2,
    st_refill_drop = 3'd3,  // drain a burst cut by a flush
    st_direct_drop = 3'd4,
    st_ready       = 3'd5   // line is in, hand out the word
  } fetch_state_e;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [7:0]  len;
    logic [2:0]  size;
    logic [1:0]  burst;
  } axi_ar_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic [1:0]  resp;
    logic        last;
  } axi_r_t;

  typedef struct packed {
    logic [31:0] inst;
    logic [31:0] pc;
    logic        exception;
    logic [3:0]  mcause;
  } fetch_out_t;

endpackage

/* icache/icache_store.sv */
`timescale 1ns/1ps

module icache_store (
  input  logic                            i_clock,
  input  logic                            i_reset,
  input  logic                            i_fencei,
  input  logic [31:0]                     i_pc,
  input  logic                            i_fill,
  input  logic [fetch_pkg::LINE_BITS-1:0] i_fill_line,
  input  logic [fetch_pkg::BEAT_BITS-1:0] i_fill_beat,
  input  logic [31:0]                     i_fill_data,
  input  logic [fetch_pkg::TAG_BITS-1:0]  i_fill_tag,
  output logic                            o_hit,
  output logic [31:0]                     o_word
);
  import fetch_pkg::*;

  logic [TAG_BITS-1:0] tag_array [LINE_COUNT];
  logic [31:0] data_array [LINE_COUNT][WORDS_PER_LINE];
  logic [LINE_COUNT-1:0][WORDS_PER_LINE-1:0] valid_bits;  // one bit per word

  logic [TAG_BITS-1:0] pc_tag;
  logic [LINE_BITS-1:0] pc_line;
  logic [BEAT_BITS-1:0] pc_word;
  logic [WORDS_PER_LINE-1:0] fill_mask;

  assign pc_tag = i_pc[31 -: TAG_BITS];
  assign pc_line = i_pc[OFFSET_BITS +: LINE_BITS];
  assign pc_word = i_pc[2 +: BEAT_BITS];

  assign fill_mask = {{(WORDS_PER_LINE - 1){1'b0}}, 1'b1} << i_fill_beat;

  // bursts are line aligned, so beat 0 always opens a new line
  always_ff @(posedge i_clock) begin
    if (i_reset || i_fencei) begin
      valid_bits <= '0;
    end else if (i_fill) begin
      if (i_fill_beat == '0) begin
        valid_bits[i_fill_line] <= fill_mask;  // drop words of the old tag
      end else begin
        valid_bits[i_fill_line] <= valid_bits[i_fill_line] | fill_mask;
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_fill) begin
      tag_array[i_fill_line] <= i_fill_tag;
      data_array[i_fill_line][i_fill_beat] <= i_fill_data;
    end
  end

  assign o_hit = valid_bits[pc_line][pc_word] && (tag_array[pc_line] == pc_tag);
  assign o_word = data_array[pc_line][pc_word];

endmodule

/* icache/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl (
  input  logic                            i_clock,
  input  logic                            i_reset,
  input  logic                            i_flush,
  input  logic                            i_ready,
  input  logic [31:0]                     i_pc,
  input  logic                            i_hit,
  input  logic [31:0]                     i_word,
  input  fetch_pkg::axi_r_t               i_axi_r,
  input  logic                            i_axi_arready,
  output fetch_pkg::axi_ar_t              o_axi_ar,
  output logic                            o_fill,
  output logic [fetch_pkg::LINE_BITS-1:0] o_fill_line,
  output logic [fetch_pkg::BEAT_BITS-1:0] o_fill_beat,
  output logic [31:0]                     o_fill_data,
  output logic [fetch_pkg::TAG_BITS-1:0]  o_fill_tag,
  output logic                            o_advance,
  output logic                            o_valid,
  output fetch_pkg::fetch_out_t           o_fetch
);
  import fetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;

  logic valid_q;
  fetch_out_t fetch_q;

  logic ar_valid;
  logic [31:0] ar_addr;
  logic [7:0] ar_len;

  logic [31:0] req_pc;  // pc of the read in flight
  logic [BEAT_BITS-1:0] beat_cnt;
  logic refill_err;  // stop filling once a beat fails
  logic [31:0] hold_word;  // beat that carries the requested word
  logic hold_err;

  logic out_free;
  logic misaligned;
  logic bypass;
  logic cache_hit;
  logic idle_go;
  logic start_miss;
  logic refilling;
  logic beat;
  logic beat_ok;
  logic want_beat;
  logic load_out;
  logic [31:0] load_inst;
  logic load_exc;

  assign out_free = !valid_q || i_ready;  // output register empty or drained this cycle
  assign misaligned = i_pc[1:0] != 2'b00;
  assign bypass = i_pc[31:24] == BYPASS_REGION;
  assign cache_hit = i_hit && !bypass;
  assign idle_go = (state_q == st_idle) && !i_flush && out_free;
  assign start_miss = idle_go && !misaligned && !cache_hit;

  assign refilling = (state_q == st_refill) || (state_q == st_refill_drop);
  assign beat = i_axi_r.valid;
  assign beat_ok = i_axi_r.resp == AXI_RESP_OKAY;
  assign want_beat = beat_cnt == req_pc[2 +: BEAT_BITS];

  // what goes into the output register this cycle
  always_comb begin
    load_out = 1'b0;
    load_inst = i_word;
    load_exc = 1'b0;
    case (state_q)
      st_idle: begin
        load_out = idle_go && (misaligned || cache_hit);
        load_inst = misaligned ? 32'd0 : i_word;
        load_exc = misaligned;
      end
      st_direct: begin
        load_out = beat && !i_flush;
        load_inst = i_axi_r.data;
        load_exc = !beat_ok;
      end
      st_ready: begin
        load_out = !i_flush && out_free;
        load_inst = hold_word;
        load_exc = hold_err;
      end
      default: begin
        load_out = 1'b0;
      end
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (start_miss) state_d = bypass ? st_direct : st_refill;
      end
      st_refill: begin
        if (beat && i_axi_r.last) begin
          state_d = i_flush ? st_idle : st_ready;
        end else if (i_flush) begin
          state_d = st_refill_drop;
        end
      end
      st_direct: begin
        if (beat) begin
          state_d = st_idle;  // a flush on this beat just drops the word
        end else if (i_flush) begin
          state_d = st_direct_drop;
        end
      end
      st_refill_drop: begin
        if (beat && i_axi_r.last) state_d = st_idle;
      end
      st_direct_drop: begin
        if (beat) state_d = st_idle;
      end
      st_ready: begin
        if (load_out || i_flush) state_d = st_idle;
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      state_q <= st_idle;
      valid_q <= 1'b0;
      ar_valid <= 1'b0;
      beat_cnt <= '0;
      refill_err <= 1'b0;
    end else begin
      state_q <= state_d;

      if (i_flush) begin
        valid_q <= 1'b0;
      end else if (load_out) begin
        valid_q <= 1'b1;
      end else if (i_ready) begin
        valid_q <= 1'b0;
      end

      if (start_miss) begin
        ar_valid <= 1'b1;
      end else if (i_axi_arready) begin
        ar_valid <= 1'b0;
      end

      if (start_miss) begin
        beat_cnt <= '0;
        refill_err <= 1'b0;
      end else if (refilling && beat) begin
        beat_cnt <= beat_cnt + 1'b1;
        if (!beat_ok) refill_err <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (start_miss) begin
      req_pc <= i_pc;
      ar_addr <= bypass ? i_pc : {i_pc[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
      ar_len <= bypass ? 8'd0 : REFILL_LEN;
    end
    if ((state_q == st_refill) && beat && want_beat) begin
      hold_word <= i_axi_r.data;
      hold_err <= !beat_ok;
    end
    if (load_out) begin
      fetch_q.inst <= load_inst;
      fetch_q.pc <= i_pc;
      fetch_q.exception <= load_exc;
      fetch_q.mcause <= load_exc ? MCAUSE_FETCH_FAULT : 4'd0;
    end
  end

  assign o_axi_ar = '{
    valid: ar_valid,
    addr:  ar_addr,
    len:   ar_len,
    size:  AXI_SIZE_4B,
    burst: AXI_BURST_INCR
  };

  // failed beats never reach the arrays
  assign o_fill = refilling && beat && beat_ok && !refill_err;
  assign o_fill_line = req_pc[OFFSET_BITS +: LINE_BITS];
  assign o_fill_beat = beat_cnt;
  assign o_fill_data = i_axi_r.data;
  assign o_fill_tag = req_pc[31 -: TAG_BITS];

  assign o_advance = load_out;
  assign o_valid = valid_q;
  assign o_fetch = fetch_q;

endmodule

/* logic/fetch_pc.sv */
`timescale 1ns/1ps

module fetch_pc (
  input  logic        i_clock,
  input  logic        i_reset,
  input  logic        i_flush,
  input  logic [31:0] i_target,
  input  logic        i_advance,
  output logic [31:0] o_pc
);
  import fetch_pkg::*;

  logic [31:0] pc_q;
  logic [31:0] pc_seq;  // next instruction in line

  assign pc_seq = pc_q + 32'(INST_BYTES);

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      pc_q <= RESET_PC;
    end else if (i_flush) begin
      pc_q <= i_target;  // redirect beats a same-cycle advance
    end else if (i_advance) begin
      pc_q <= pc_seq;
    end
  end

  assign o_pc = pc_q;

endmodule

/* logic/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
  input  logic                  i_clock,
  input  logic                  i_reset,
  input  logic                  i_ready,
  input  logic                  i_flush,
  input  logic [31:0]           i_target,
  input  logic                  i_fencei,
  output logic                  o_valid,
  output fetch_pkg::fetch_out_t o_fetch,
  output logic [31:0]           o_axi_araddr,
  output logic                  o_axi_arvalid,
  output logic [7:0]            o_axi_arlen,
  output logic [2:0]            o_axi_arsize,
  output logic [1:0]            o_axi_arburst,
  output logic                  o_axi_rready,
  input  logic                  i_axi_arready,
  input  logic [31:0]           i_axi_rdata,
  input  logic [1:0]            i_axi_rresp,
  input  logic                  i_axi_rlast,
  input  logic                  i_axi_rvalid
);
  import fetch_pkg::*;

  logic [31:0] pc;
  logic advance;
  logic hit;
  logic [31:0] word;

  logic fill;
  logic [LINE_BITS-1:0] fill_line;
  logic [BEAT_BITS-1:0] fill_beat;
  logic [31:0] fill_data;
  logic [TAG_BITS-1:0] fill_tag;

  axi_ar_t axi_ar;
  axi_r_t axi_r;

  assign axi_r = '{
    valid: i_axi_rvalid,
    data:  i_axi_rdata,
    resp:  i_axi_rresp,
    last:  i_axi_rlast
  };

  assign o_axi_araddr = axi_ar.addr;
  assign o_axi_arvalid = axi_ar.valid;
  assign o_axi_arlen = axi_ar.len;
  assign o_axi_arsize = axi_ar.size;
  assign o_axi_arburst = axi_ar.burst;
  assign o_axi_rready = 1'b1;  // every beat is taken as it arrives

  fetch_pc pc_i (
    .i_clock   (i_clock),
    .i_reset   (i_reset),
    .i_flush   (i_flush),
    .i_target  (i_target),
    .i_advance (advance),
    .o_pc      (pc)
  );

  icache_ctrl ctrl_i (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_flush       (i_flush),
    .i_ready       (i_ready),
    .i_pc          (pc),
    .i_hit         (hit),
    .i_word        (word),
    .i_axi_r       (axi_r),
    .i_axi_arready (i_axi_arready),
    .o_axi_ar      (axi_ar),
    .o_fill        (fill),
    .o_fill_line   (fill_line),
    .o_fill_beat   (fill_beat),
    .o_fill_data   (fill_data),
    .o_fill_tag    (fill_tag),
    .o_advance     (advance),
    .o_valid       (o_valid),
    .o_fetch       (o_fetch)
  );

  icache_store store_i (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_fencei    (i_fencei),
    .i_pc        (pc),
    .i_fill      (fill),
    .i_fill_line (fill_line),
    .i_fill_beat (fill_beat),
    .i_fill_data (fill_data),
    .i_fill_tag  (fill_tag),
    .o_hit       (hit),
    .o_word      (word)
  );

endmodule

/* test/fetch_assertions.sv */
`timescale 1ns/1ps

module fetch_assertions (
  input logic                  i_clock,
  input logic                  i_reset,
  input logic                  i_ready,
  input logic                  i_flush,
  input logic                  i_axi_arready,
  input fetch_pkg::axi_ar_t    o_axi_ar,
  input logic                  o_valid,
  input fetch_pkg::fetch_out_t o_fetch
);

  ar_held: assert property (@(posedge i_clock) disable iff (i_reset)
    o_axi_ar.valid && !i_axi_arready |=> o_axi_ar.valid)
    else $error("arvalid dropped before arready");

  ar_stable: assert property (@(posedge i_clock) disable iff (i_reset)
    o_axi_ar.valid && !i_axi_arready |=> $stable(o_axi_ar.addr) && $stable(o_axi_ar.len))
    else $error("ar address or len changed while waiting for arready");

  // back-pressure keeps the result
  fetch_held: assert property (@(posedge i_clock) disable iff (i_reset)
    o_valid && !i_ready && !i_flush |=> o_valid && $stable(o_fetch))
    else $error("o_fetch changed under back-pressure");

endmodule

bind icache_ctrl fetch_assertions assertions_i (
  .i_clock       (i_clock),
  .i_reset       (i_reset),
  .i_ready       (i_ready),
  .i_flush       (i_flush),
  .i_axi_arready (i_axi_arready),
  .o_axi_ar      (o_axi_ar),
  .o_valid       (o_valid),
  .o_fetch       (o_fetch)
);

/* test/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;
  import fetch_pkg::*;

  localparam int CLOCK_PERIOD = 10;
  localparam int CYCLES_PER_CASE = 200;
  localparam logic [31:0] DATA_XOR = 32'h5a5a_0000;  // memory word = address ^ this

  logic i_clock = 1'b0;
  logic i_reset = 1'b1;
  logic i_ready = 1'b0;
  logic i_flush = 1'b0;
  logic [31:0] i_target = '0;
  logic i_fencei = 1'b0;
  logic o_valid;
  fetch_out_t o_fetch;
  logic [31:0] o_axi_araddr;
  logic o_axi_arvalid;
  logic [7:0] o_axi_arlen;
  logic [2:0] o_axi_arsize;
  logic [1:0] o_axi_arburst;
  logic o_axi_rready;
  logic i_axi_arready = 1'b0;
  logic [31:0] i_axi_rdata = '0;
  logic [1:0] i_axi_rresp = '0;
  logic i_axi_rlast = 1'b0;
  logic i_axi_rvalid = 1'b0;

  int seed = 91567;
  int ar_count = 0;
  int case_total = 0;
  logic [31:0] exp_pc = 32'h8000_0000;
  logic [31:0] fault_list [$];
  logic [8*8-1:0] case_cmd [$];
  logic [31:0] case_arg [$];
  int case_ar [$];

  // memory model state
  logic busy = 1'b0;
  logic [31:0] rd_addr = '0;
  int beats_left = 0;
  int ar_wait = 0;
  int beat_gap = 0;

  fetch_top dut_i (.*);

  always #(CLOCK_PERIOD / 2) i_clock = ~i_clock;

  function automatic int next_delay();
    return $unsigned($random(seed)) % 3;
  endfunction

  function automatic bit is_fault(input logic [31:0] addr);
    foreach (fault_list[i]) begin
      if (fault_list[i] == addr) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      stop_run($sformatf("** Error at %0t ns: %s = 0x%08h, expected 0x%08h",
                         $time, name, got, expected));
    end
  endtask

  // read kind follows the address region
  task automatic verify_ar_request();
    logic uncached;
    uncached = o_axi_araddr[31:24] == 8'h0f;
    check_value("o_axi_arlen", 32'(o_axi_arlen), uncached ? 32'd0 : 32'd1);
    check_value("o_axi_arsize", 32'(o_axi_arsize), 32'd2);  // 4 bytes per beat
    check_value("o_axi_arburst", 32'(o_axi_arburst), 32'd1);  // incr
    check_value("o_axi_rready", 32'(o_axi_rready), 32'd1);
    if (!uncached) begin
      check_value("o_axi_araddr[2:0]", 32'(o_axi_araddr[2:0]), 32'd0);  // line aligned
    end
  endtask

  // axi slave, answers at the falling edge
  always @(negedge i_clock) begin
    if (i_reset) begin
      i_axi_arready = 1'b0;
      i_axi_rvalid = 1'b0;
      busy = 1'b0;
      ar_wait = next_delay();
    end else begin
      if (i_axi_rvalid) begin  // beat taken on the last edge
        i_axi_rvalid = 1'b0;
        rd_addr = rd_addr + 32'd4;
        beats_left--;
        if (beats_left == 0) busy = 1'b0;
        beat_gap = next_delay();
      end
      if (i_axi_arready) begin  // address handshake on the last edge
        i_axi_arready = 1'b0;
        ar_count++;
        busy = 1'b1;
        beat_gap = next_delay();
        ar_wait = next_delay();
      end else if (!busy && o_axi_arvalid) begin
        if (ar_wait == 0) begin
          i_axi_arready = 1'b1;
          rd_addr = o_axi_araddr;
          beats_left = int'(o_axi_arlen) + 1;
          verify_ar_request();
        end else begin
          ar_wait--;
        end
      end
      if (busy) begin
        if (beat_gap == 0) begin
          i_axi_rdata = rd_addr ^ DATA_XOR;
          i_axi_rresp = is_fault(rd_addr) ? 2'b10 : 2'b00;  // slverr
          i_axi_rlast = beats_left == 1;
          i_axi_rvalid = 1'b1;
        end else begin
          beat_gap--;
        end
      end
    end
  end

  task automatic check_fetch();
    logic exc;
    exc = (exp_pc[1:0] != 2'b00) || is_fault(exp_pc);
    check_value("o_fetch.pc", o_fetch.pc, exp_pc);
    check_value("o_fetch.exception", 32'(o_fetch.exception), 32'(exc));
    check_value("o_fetch.mcause", 32'(o_fetch.mcause), exc ? 32'd1 : 32'd0);
    if (!exc) check_value("o_fetch.inst", o_fetch.inst, exp_pc ^ DATA_XOR);
    exp_pc = exp_pc + 32'd4;
  endtask

  // all_ready keeps i_ready high and expects a hit every clock
  task automatic run_fetches(input int count, input bit all_ready);
    int accepted;
    accepted = 0;
    while (accepted < count) begin
      @(negedge i_clock);
      i_ready = all_ready ? 1'b1 : (($unsigned($random(seed)) % 4) != 0);
      if (all_ready) check_value("o_valid", 32'(o_valid), 32'd1);
      if (o_valid && i_ready) begin
        check_fetch();
        accepted++;
      end
    end
    @(negedge i_clock);
    i_ready = 1'b0;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    do begin
      @(negedge i_clock);
      #1;
      waited++;
      if (waited > CYCLES_PER_CASE) stop_run("memory bus never went idle");
    end while (o_axi_arvalid || busy || i_axi_arready);
  endtask

  task automatic pulse_flush(input logic [31:0] target);
    @(negedge i_clock);
    i_flush = 1'b1;
    i_target = target;
    @(negedge i_clock);
    i_flush = 1'b0;
    exp_pc = target;
  endtask

  task automatic pulse_fencei();
    @(negedge i_clock);
    i_fencei = 1'b1;
    @(negedge i_clock);
    i_fencei = 1'b0;
  endtask

  task automatic load_cases();
    int fd;
    int n;
    logic [8*128-1:0] line_buf;
    logic [8*8-1:0] cmd;
    logic [31:0] arg;
    int exp_ar;
    fd = $fopen("test/fetch_cases.txt", "r");
    if (fd == 0) stop_run("cannot open test/fetch_cases.txt");
    while (!$feof(fd)) begin
      line_buf = '0;
      if ($fgets(line_buf, fd) != 0) begin
        n = $sscanf(line_buf, "%s %h %d", cmd, arg, exp_ar);
        if (n >= 1 && cmd != "#") begin
          if (n != 3) stop_run("malformed line in case file");
          case_cmd.push_back(cmd);
          case_arg.push_back(arg);
          case_ar.push_back(exp_ar);
        end
      end
    end
    $fclose(fd);
    if (case_cmd.size() == 0) stop_run("case file holds no commands");
    case_total = case_cmd.size();
  endtask

  initial begin
    load_cases();
    repeat (3) @(negedge i_clock);
    i_reset = 1'b0;
    foreach (case_cmd[i]) begin
      case (case_cmd[i])
        "run": begin
          run_fetches(int'(case_arg[i]), 1'b0);
          wait_idle();
        end
        "hits": begin
          run_fetches(int'(case_arg[i]), 1'b1);
          wait_idle();
        end
        "flush": pulse_flush(case_arg[i]);
        "fencei": pulse_fencei();
        "stall": repeat (int'(case_arg[i])) @(negedge i_clock);
        "fault": fault_list.push_back(case_arg[i]);
        default: stop_run("unknown command in case file");
      endcase
      if (case_ar[i] >= 0) begin
        #1;
        check_value("ar_count", 32'(ar_count), 32'(case_ar[i]));
      end
    end
    $display(">>> PASS");
    $finish;
  end

  initial begin
    wait (case_total > 0);
    #(case_total * CYCLES_PER_CASE * CLOCK_PERIOD);
    stop_run("watchdog expired before the case list finished");
  end

endmodule

/* test/fetch_cases.txt */
# command   argument in hex   expected AR count so far or -1 for no check
# commands are run, hits, flush, fencei, stall and fault
run    8        5
flush  80000008 5
hits   6        5
fencei 0        5
run    2        7
flush  0f000100 7
run    3        11
flush  0f000100 11
run    1        13
flush  80000040 13
stall  1        -1
flush  80000100 -1
run    1        15
fault  80000108 15
run    2        17
flush  80000202 17
run    1        17
flush  80000000 17
run    10       26
stall  8        26
run    4        28
flush  80000040 28
hits   4        28

/* filelist.f */
common/fetch_pkg.sv
icache/icache_store.sv
icache/icache_ctrl.sv
logic/fetch_pc.sv
logic/fetch_top.sv
test/fetch_assertions.sv
test/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module fetch_tb -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vfetch_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q '>>> FAIL' sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
if grep -q '>>> PASS' sim.log; then
  exit 0
fi
echo "simulation ended without a result"
exit 1
